//--- Bender.yml
package:
  name: fc_layer

sources:
  - common/fc_pkg.sv
  - control/fc_seq_counter.sv
  - control/fc_fsm.sv
  - datapath/x_buffer.sv
  - datapath/weight_rom.sv
  - datapath/sat_mac.sv
  - verilog/fc_layer.sv
  - target: test
    files:
      - sim/fc_layer_props.sv
      - sim/tb_fc_layer.sv

//--- common/fc_pkg.sv
// Shared sizes and types for the fully connected layer
// Arithmetic is signed 32-bit fixed integer with saturation
// WEIGHT_FILE is opened relative to the simulator's working directory
package fc_pkg;

        // Layer geometry
        localparam int N_IN    = 8;
        localparam int N_OUT   = 4;
        localparam int DATA_W  = 32;
        localparam int COL_W   = $clog2(N_IN);
        localparam int WADDR_W = $clog2(N_IN * N_OUT);

        // Row-major weights, one hex word per line
        localparam string WEIGHT_FILE = "datapath/weights.hex";

        typedef logic signed [DATA_W-1:0] data_t;
        typedef logic [COL_W-1:0]         col_t;
        typedef logic [WADDR_W-1:0]       waddr_t;

        // Saturation limits
        localparam data_t DATA_MAX = {1'b0, {(DATA_W-1){1'b1}}};
        localparam data_t DATA_MIN = {1'b1, {(DATA_W-1){1'b0}}};

        // Tag that follows one multiply down the pipeline
        typedef struct packed {
                logic valid;
                logic first;
                logic last;
        } mac_op_t;

        typedef enum logic [1:0] {
                LOAD,
                EXEC,
                DRAIN,
                OUT
        } fc_state_t;

endpackage

//--- control/fc_fsm.sv
// Sequencer for load, execute, drain and output phases
// Issues one multiply per EXEC cycle, so EXEC lasts exactly N_IN cycles
// Stream outputs are decoded from the state register only
`timescale 1ns/10ps

module fc_fsm import fc_pkg::*; (
        input  logic    clk,
        input  logic    reset,
        input  logic    input_valid,
        input  logic    output_ready,
        input  logic    col_last,
        input  logic    w_last,
        input  logic    row_done,
        output logic    input_ready,
        output logic    output_valid,
        output logic    x_wr,
        output logic    col_step,
        output logic    col_clear,
        output logic    w_step,
        output logic    w_clear,
        output mac_op_t issue_op
);

        fc_state_t state, next_state;
        logic      row_first;

        always_ff @(posedge clk) begin
                if (reset) begin
                        state <= LOAD;
                end else begin
                        state <= next_state;
                end
        end

        // Marks the first EXEC cycle of every row
        always_ff @(posedge clk) begin
                if (reset) begin
                        row_first <= 1'b0;
                end else begin
                        row_first <= (state != EXEC) && (next_state == EXEC);
                end
        end

        always_comb begin
                next_state = state;
                case (state)
                        LOAD: begin
                                if (input_valid && col_last)
                                        next_state = EXEC;
                        end
                        EXEC: begin
                                if (col_last)
                                        next_state = DRAIN;
                        end
                        DRAIN: begin
                                if (row_done)
                                        next_state = OUT;
                        end
                        OUT: begin
                                // Last row leaves waddr parked on the final weight
                                if (output_ready)
                                        next_state = w_last ? LOAD : EXEC;
                        end
                        default: next_state = LOAD;
                endcase
        end

        always_comb begin
                input_ready  = (state == LOAD);
                output_valid = (state == OUT);
                x_wr         = 1'b0;
                col_step     = 1'b0;
                col_clear    = 1'b0;
                w_step       = 1'b0;
                w_clear      = 1'b0;
                issue_op     = '0;
                case (state)
                        LOAD: begin
                                x_wr      = input_valid;
                                col_step  = input_valid && !col_last;
                                col_clear = input_valid && col_last;
                        end
                        EXEC: begin
                                issue_op.valid = 1'b1;
                                issue_op.first = row_first;
                                issue_op.last  = col_last;
                                // Column holds on its last value until OUT clears it
                                col_step = !col_last;
                                w_step   = !w_last;
                        end
                        OUT: begin
                                col_clear = output_ready;
                                w_clear   = output_ready && w_last;
                        end
                        default: ;
                endcase
        end

endmodule

//--- control/fc_seq_counter.sv
// Column and weight address counters for the layer sequencer
// Clear wins over step when both are strobed in the same cycle
`timescale 1ns/10ps

module fc_seq_counter import fc_pkg::*; (
        input  logic   clk,
        input  logic   reset,
        input  logic   col_step,
        input  logic   col_clear,
        input  logic   w_step,
        input  logic   w_clear,
        output col_t   col,
        output waddr_t waddr,
        output logic   col_last,
        output logic   w_last
);

        localparam col_t   COL_END = col_t'(N_IN - 1);
        localparam waddr_t W_END   = waddr_t'(N_IN * N_OUT - 1);

        // Column index into the x buffer
        always_ff @(posedge clk) begin
                if (reset || col_clear) begin
                        col <= '0;
                end else if (col_step) begin
                        col <= col + 1'b1;
                end
        end

        // Running weight address, row-major across all rows
        always_ff @(posedge clk) begin
                if (reset || w_clear) begin
                        waddr <= '0;
                end else if (w_step) begin
                        waddr <= waddr + 1'b1;
                end
        end

        assign col_last = (col == COL_END);
        assign w_last   = (waddr == W_END);

endmodule

//--- datapath/sat_mac.sv
// Saturating multiply-accumulate with ReLU on the row result
// Tag stage 1 lines up with memory read data, stage 2 with the product
// row_done is combinational from stage 2 and result updates on that edge
`timescale 1ns/10ps

module sat_mac import fc_pkg::*; (
        input  logic    clk,
        input  logic    reset,
        input  mac_op_t issue_op,
        input  data_t   x_data,
        input  data_t   w_data,
        output logic    row_done,
        output data_t   result
);

        mac_op_t op_d1, op_d2;
        data_t   prod_q;
        data_t   acc_q;
        data_t   acc_next;

        // Full width product clipped back to DATA_W
        function automatic data_t sat_mul(data_t a, data_t b);
                logic signed [2*DATA_W-1:0] full;
                full = a * b;
                if (full > DATA_MAX)
                        return DATA_MAX;
                else if (full < DATA_MIN)
                        return DATA_MIN;
                return data_t'(full);
        endfunction

        // Overflow only when both operands share a sign the sum lost
        function automatic data_t sat_add(data_t a, data_t b);
                data_t s;
                s = a + b;
                if ((a[DATA_W-1] == b[DATA_W-1]) && (s[DATA_W-1] != a[DATA_W-1]))
                        s = a[DATA_W-1] ? DATA_MIN : DATA_MAX;
                return s;
        endfunction

        // Tag pipeline
        always_ff @(posedge clk) begin
                if (reset) begin
                        op_d1 <= '0;
                        op_d2 <= '0;
                end else begin
                        op_d1 <= issue_op;
                        op_d2 <= op_d1;
                end
        end

        // Product register
        always_ff @(posedge clk) begin
                prod_q <= sat_mul(x_data, w_data);
        end

        // First tag of a row restarts the sum
        assign acc_next = op_d2.first ? prod_q : sat_add(acc_q, prod_q);

        always_ff @(posedge clk) begin
                if (op_d2.valid) begin
                        acc_q <= acc_next;
                end
                if (op_d2.valid && op_d2.last) begin
                        result <= acc_next[DATA_W-1] ? '0 : acc_next;
                end
        end

        assign row_done = op_d2.valid && op_d2.last;

endmodule

//--- datapath/weight_rom.sv
// Weight ROM, N_OUT rows of N_IN signed words in row-major order
// Contents come from WEIGHT_FILE at elaboration
// Read data is registered and appears one cycle after the address
`timescale 1ns/10ps

module weight_rom import fc_pkg::*; (
        input  logic   clk,
        input  waddr_t addr,
        output data_t  rdata
);

        data_t rom [N_IN * N_OUT];

        initial begin
                $readmemh(WEIGHT_FILE, rom);
        end

        always_ff @(posedge clk) begin
                rdata <= rom[addr];
        end

endmodule

//--- datapath/weights.hex
// Layer weights, row-major, N_IN words per row, one signed 32-bit hex word per line
00000003
fffffffe
00000005
00000001
fffffff9
00000002
00000004
ffffffff
ffffffff
ffffffff
fffffffd
fffffffc
00000001
fffffffe
ffffffff
fffffffb
00000100
00000007
fffff000
00000002
0000000a
fffffffa
00000003
00000009
00000001
00000002
00000003
00000004
00000005
00000006
00000007
00000008

//--- datapath/x_buffer.sv
// Input vector store, N_IN words
// Read data is registered and appears one cycle after the address
// A write returns the old word on the same cycle's read
`timescale 1ns/10ps

module x_buffer import fc_pkg::*; (
        input  logic  clk,
        input  logic  wr,
        input  col_t  addr,
        input  data_t wdata,
        output data_t rdata
);

        data_t mem [N_IN];

        always_ff @(posedge clk) begin
                if (wr) begin
                        mem[addr] <= wdata;
                end
                rdata <= mem[addr];
        end

endmodule

//--- list.f
common/fc_pkg.sv
control/fc_seq_counter.sv
control/fc_fsm.sv
datapath/x_buffer.sv
datapath/weight_rom.sv
datapath/sat_mac.sv
verilog/fc_layer.sv
sim/fc_layer_props.sv
sim/tb_fc_layer.sv

//--- sim/fc_layer_props.sv
// Stream protocol checks for fc_layer, attached by bind
// Reset disables the handshake checks for the cycle it is sampled
`timescale 1ns/10ps

module fc_layer_props import fc_pkg::*; (
        input logic    clk,
        input logic    reset,
        input logic    input_ready,
        input logic    output_valid,
        input logic    output_ready,
        input data_t   output_data,
        input mac_op_t issue_op
);

        // A result stays offered until it is taken
        a_valid_hold: assert property (@(posedge clk) disable iff (reset)
                output_valid && !output_ready |=> output_valid)
                else $error("output_valid dropped before output_ready was seen");

        a_data_stable: assert property (@(posedge clk) disable iff (reset)
                output_valid && !output_ready |=> $stable(output_data))
                else $error("output_data changed while waiting for output_ready");

        a_one_stream: assert property (@(posedge clk) disable iff (reset)
                !(input_ready && output_valid))
                else $error("input_ready and output_valid high together");

        // Nothing is offered or issued right after reset
        a_reset_quiet: assert property (@(posedge clk)
                reset |=> !output_valid && !issue_op.valid)
                else $error("output_valid or an issue seen in the cycle after reset");

endmodule

bind fc_layer fc_layer_props u_props (.*);

//--- sim/tb_fc_layer.sv
// Testbench for fc_layer
// Run from the project root so WEIGHT_FILE resolves
// Each vector waits for all N_OUT results before the next one is loaded
`timescale 1ns/10ps

module tb_fc_layer import fc_pkg::*;;

        localparam logic [31:0] SEED = 32'h1c09_3fd8;
        localparam int N_VEC = 19;
        localparam int CYCLE_LIMIT = 10 * (N_VEC * (N_IN + N_OUT) + N_VEC * N_OUT * (N_IN + 3));
        localparam int K_SMALL = 0, K_LARGE = 1, K_POS = 2, K_NEG = 3, K_MAX = 4, K_MIN = 5;

        logic  clk = 1'b0;
        logic  reset, input_valid, input_ready, output_valid, output_ready;
        data_t input_data, output_data;

        logic [31:0] lfsr_state = SEED;
        data_t w_ref [N_IN * N_OUT];
        data_t x_vec [N_IN];
        data_t exp_q [$];
        int    ready_mode;
        logic  busy;
        int    errors = 0, checks = 0, tests = 0, cycles = 0;
        int    err_start, chk_start;

        fc_layer u_dut (.*);

        initial begin
                forever #2 clk = ~clk;
        end

        function automatic logic [31:0] lfsr_step(input logic [31:0] s);
                if (s[0])
                        return (s >> 1) ^ 32'hA300_0000;
                return s >> 1;
        endfunction

        function automatic logic [31:0] rand_bits(input int n);
                logic [31:0] r;
                r = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr_state = lfsr_step(lfsr_state);
                        r = {r[30:0], lfsr_state[0]};
                end
                return r;
        endfunction

        function automatic data_t clip(input logic signed [63:0] v);
                if (v > DATA_MAX)
                        return DATA_MAX;
                if (v < DATA_MIN)
                        return DATA_MIN;
                return data_t'(v);
        endfunction

        // Saturate every product and every partial sum, then ReLU
        function automatic data_t ref_row(input int row);
                logic signed [63:0] a, b, sum;
                data_t acc;
                acc = '0;
                for (int k = 0; k < N_IN; k++) begin
                        a = x_vec[k];
                        b = w_ref[row * N_IN + k];
                        sum = acc;
                        sum = sum + clip(a * b);
                        acc = clip(sum);
                end
                return acc[DATA_W-1] ? '0 : acc;
        endfunction

        task automatic prepare_vector(input int kind);
                logic [31:0] r;
                for (int k = 0; k < N_IN; k++) begin
                        r = rand_bits(16);
                        case (kind)
                                K_SMALL: x_vec[k] = {{16{r[15]}}, r[15:0]};
                                K_LARGE: x_vec[k] = r[15] ? DATA_MAX - r[7:0] : DATA_MIN + r[7:0];
                                K_POS:   x_vec[k] = data_t'(r[11:0]);
                                K_NEG:   x_vec[k] = -data_t'(r[11:0]) - 1;
                                K_MAX:   x_vec[k] = DATA_MAX;
                                default: x_vec[k] = DATA_MIN;
                        endcase
                end
                for (int row = 0; row < N_OUT; row++)
                        exp_q.push_back(ref_row(row));
        endtask

        task automatic load_vector(input bit gaps);
                for (int k = 0; k < N_IN; k++) begin
                        while (gaps && rand_bits(1)) begin
                                input_valid <= 1'b0;
                                @(posedge clk);
                        end
                        input_valid <= 1'b1;
                        input_data  <= x_vec[k];
                        @(posedge clk);
                        while (!input_ready)
                                @(posedge clk);
                end
                input_valid <= 1'b0;
                busy        <= 1'b1;
        endtask

        task automatic run_vector(input int kind, input bit gaps);
                prepare_vector(kind);
                load_vector(gaps);
                while (exp_q.size() != 0)
                        @(posedge clk);
                @(posedge clk);
        endtask

        // Results in flight are dropped, so the expected queue goes too
        task automatic apply_reset();
                reset <= 1'b1;
                exp_q.delete();
                busy <= 1'b0;
                repeat (3) @(posedge clk);
                reset <= 1'b0;
                @(posedge clk);
                assert (input_ready && !output_valid) else begin
                        $display("DUT did not return to loading after reset at %0t", $time);
                        errors++;
                end
        endtask

        task automatic start_test();
                tests++;
                err_start = errors;
                chk_start = checks;
        endtask

        task automatic report_test(input string name);
                $display("Test %0d %s: %0d checks, %0d errors", tests, name,
                         checks - chk_start, errors - err_start);
        endtask

        // Ready modes 0 always ready, 1 random while offered and 2 held low
        always @(posedge clk) begin
                if (ready_mode == 0)
                        output_ready <= 1'b1;
                else if (ready_mode == 2)
                        output_ready <= 1'b0;
                else if (output_valid)
                        output_ready <= (rand_bits(1) != 0);
        end

        always @(posedge clk) begin
                data_t exp;
                if (!reset && output_valid && output_ready) begin
                        assert (exp_q.size() != 0) else begin
                                $display("Unexpected result %h with none pending at %0t",
                                         output_data, $time);
                                errors++;
                        end
                        if (exp_q.size() != 0) begin
                                exp = exp_q.pop_front();
                                checks++;
                                assert (output_data === exp) else begin
                                        $display("FAIL t=%0t output_data got %h expected %h",
                                                 $time, output_data, exp);
                                        errors++;
                                end
                                if (exp_q.size() == 0)
                                        busy <= 1'b0;
                        end
                end
                assert (reset || !(busy && input_ready)) else begin
                        $display("input_ready went high at %0t before all results were taken",
                                 $time);
                        errors++;
                end
        end

        always @(posedge clk) begin
                cycles++;
                if (cycles >= CYCLE_LIMIT) begin
                        $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
                        $display("*** TEST FAILED ***");
                        $finish;
                end
        end

        initial begin
                reset        = 1'b1;
                input_valid  = 1'b0;
                input_data   = '0;
                output_ready = 1'b0;
                ready_mode   = 0;
                busy         = 1'b0;
                $readmemh(WEIGHT_FILE, w_ref);
                repeat (8) @(posedge clk);
                reset <= 1'b0;
                @(posedge clk);

                start_test();
                repeat (4) run_vector(K_SMALL, 1'b0);
                report_test("random small vectors");

                start_test();
                run_vector(K_LARGE, 1'b0);
                run_vector(K_MAX, 1'b0);
                run_vector(K_MIN, 1'b0);
                report_test("saturation near the limits");

                start_test();
                run_vector(K_POS, 1'b0);
                run_vector(K_NEG, 1'b0);
                report_test("negative rows clamp to zero");

                start_test();
                ready_mode <= 1;
                repeat (3) run_vector(K_SMALL, 1'b0);
                report_test("output back-pressure");

                start_test();
                ready_mode <= 0;
                repeat (4) run_vector(K_SMALL, 1'b1);
                report_test("gaps in input_valid");

                start_test();
                ready_mode <= 2;
                prepare_vector(K_SMALL);
                load_vector(1'b0);
                while (!output_valid)
                        @(posedge clk);
                apply_reset();
                ready_mode <= 0;
                prepare_vector(K_LARGE);
                load_vector(1'b0);
                repeat (3) @(posedge clk);
                apply_reset();
                run_vector(K_SMALL, 1'b0);
                report_test("reset during work");

                $display("Done: %0d tests, %0d checks, %0d errors", tests, checks, errors);
                if (errors == 0)
                        $display("*** TEST PASSED ***");
                else
                        $display("*** TEST FAILED ***");
                $finish;
        end

endmodule

//--- verilog/fc_layer.sv
// Fully connected layer, N_OUT rows by N_IN inputs
// One vector is loaded, then one ReLU result per row is streamed out
// No new vector is accepted until the last row result has been taken
`timescale 1ns/10ps

module fc_layer import fc_pkg::*; (
        input  logic  clk,
        input  logic  reset,
        input  logic  input_valid,
        input  data_t input_data,
        output logic  input_ready,
        output logic  output_valid,
        input  logic  output_ready,
        output data_t output_data
);

        logic    x_wr;
        logic    col_step, col_clear, w_step, w_clear;
        logic    col_last, w_last;
        logic    row_done;
        col_t    col;
        waddr_t  waddr;
        data_t   x_rdata, w_rdata;
        mac_op_t issue_op;

        // Control
        fc_fsm u_fsm (
                .clk          (clk),
                .reset        (reset),
                .input_valid  (input_valid),
                .output_ready (output_ready),
                .col_last     (col_last),
                .w_last       (w_last),
                .row_done     (row_done),
                .input_ready  (input_ready),
                .output_valid (output_valid),
                .x_wr         (x_wr),
                .col_step     (col_step),
                .col_clear    (col_clear),
                .w_step       (w_step),
                .w_clear      (w_clear),
                .issue_op     (issue_op)
        );

        fc_seq_counter u_seq (
                .clk       (clk),
                .reset     (reset),
                .col_step  (col_step),
                .col_clear (col_clear),
                .w_step    (w_step),
                .w_clear   (w_clear),
                .col       (col),
                .waddr     (waddr),
                .col_last  (col_last),
                .w_last    (w_last)
        );

        // Datapath
        x_buffer u_xbuf (
                .clk   (clk),
                .wr    (x_wr),
                .addr  (col),
                .wdata (input_data),
                .rdata (x_rdata)
        );

        weight_rom u_wrom (
                .clk   (clk),
                .addr  (waddr),
                .rdata (w_rdata)
        );

        sat_mac u_mac (
                .clk      (clk),
                .reset    (reset),
                .issue_op (issue_op),
                .x_data   (x_rdata),
                .w_data   (w_rdata),
                .row_done (row_done),
                .result   (output_data)
        );

endmodule
